//--- filelist.f
+incdir+.
disasm_pkg.sv
instrDecoder.sv
operandFormatter.sv
pipeStage.sv
disassembler.sv
tb_disassembler.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_disassembler -f filelist.f -o simv > build.log 2>&1 ||
{ cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simv 2>&1 | tee sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0

//--- tb_disassembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "disasm_consts.svh"

module tb_disassembler import disasm_pkg::*; ();

  localparam int clkPeriod = 8;
  // Upper bound on the words sent by all tests
  localparam int totalItems = 140;
  localparam int watchdogCycles = 40 * totalItems + 200;

  logic       clk;
  logic       rst;
  logic       instrValid;
  logic       instrReady;
  instrWord_t instr;
  logic       lineValid;
  logic       lineReady;
  textLine_t  line;

  integer    seed;
  int        errors;
  int        sent;
  int        received;
  bit        stressReady;
  bit        anyAccepted;
  bit        expReady;
  textLine_t curExp;
  textLine_t expLine;
  textLine_t expQ[$];

  disassembler u_dut (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .instr      (instr),
    .lineValid  (lineValid),
    .lineReady  (lineReady),
    .line       (line)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
    $display("Checks failed");
    $finish;
  end

  // Random back-pressure on the output side
  always @(posedge clk) begin
    if (stressReady) lineReady <= 1'($random(seed));
    else lineReady <= 1'b1;
  end

  // Pop before push keeps a line leaving and a word entering on one edge in order
  always @(posedge clk) begin
    if (!rst && !anyAccepted) begin
      assert (!lineValid) else begin
        errors++;
        $display("CHECK FAILED at %0t: lineValid got %b expected 0 before any word",
                 $time, lineValid);
      end
    end
    // Both stages hold a word exactly when two words are outstanding
    if (!rst) begin
      expReady = !(expQ.size() == 2 && !lineReady);
      assert (instrReady == expReady) else begin
        errors++;
        $display("CHECK FAILED at %0t: instrReady got %b expected %b",
                 $time, instrReady, expReady);
      end
    end
    if (!rst && lineValid && lineReady) begin
      received++;
      assert (expQ.size() > 0) else begin
        errors++;
        $display("A line came out at %0t with no word outstanding", $time);
      end
      if (expQ.size() > 0) begin
        expLine = expQ.pop_front();
        assert (line == expLine) else begin
          errors++;
          $display("CHECK FAILED at %0t: line got \"%s\" expected \"%s\"",
                   $time, lineText(line), lineText(expLine));
        end
      end
    end
    if (!rst && instrValid && instrReady) begin
      anyAccepted = 1'b1;
      sent++;
      expQ.push_back(curExp);
    end
  end

  // Drops the NUL padding for printing
  function automatic string lineText(textLine_t t);
    string s;
    s = "";
    for (int i = $bits(textLine_t) / 8 - 1; i >= 0; i--) begin
      if (t[i*8 +: 8] != 8'h00) s = $sformatf("%s%c", s, t[i*8 +: 8]);
    end
    return s;
  endfunction

  // Holds the word until it is taken
  task automatic sendWord(input instrWord_t w, input textLine_t t);
    instrValid <= 1'b1;
    instr <= w;
    curExp <= t;
    @(posedge clk);
    while (!instrReady) @(posedge clk);
  endtask

  task automatic sendRType(input string name, input logic [6:0] f7, input logic [2:0] f3);
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    textLine_t  t;
    rd = 5'($random(seed));
    rs1 = 5'($random(seed));
    rs2 = 5'($random(seed));
    $sformat(t, "%s x%0d, x%0d, x%0d", name, rd, rs1, rs2);
    sendWord({f7, rs2, rs1, f3, rd, `OPC_OP}, t);
  endtask

  task automatic sendImm(input string name, input logic [2:0] f3, input logic [11:0] field,
                         input int shown);
    logic [4:0] rd;
    logic [4:0] rs1;
    textLine_t  t;
    rd = 5'($random(seed));
    rs1 = 5'($random(seed));
    $sformat(t, "%s x%0d, x%0d, %0d", name, rd, rs1, shown);
    sendWord({field, rs1, f3, rd, `OPC_OPIMM}, t);
  endtask

  // Loads, JALR and stores share the offset(base) form
  task automatic sendMem(input string name, input logic [6:0] opc, input logic [2:0] f3,
                         input logic [11:0] off);
    logic [4:0] ra;
    logic [4:0] base;
    textLine_t  t;
    ra = 5'($random(seed));
    base = 5'($random(seed));
    $sformat(t, "%s x%0d, %0d(x%0d)", name, ra, int'($signed(off)), base);
    if (opc == `OPC_STORE) sendWord({off[11:5], ra, base, f3, off[4:0], opc}, t);
    else sendWord({off, base, f3, ra, opc}, t);
  endtask

  task automatic sendBranch(input string name, input logic [2:0] f3, input logic [12:0] off);
    logic [4:0] rs1;
    logic [4:0] rs2;
    textLine_t  t;
    rs1 = 5'($random(seed));
    rs2 = 5'($random(seed));
    $sformat(t, "%s x%0d, x%0d, %0d", name, rs1, rs2, int'($signed(off)));
    sendWord({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH}, t);
  endtask

  task automatic sendJal(input logic [20:0] off);
    logic [4:0] rd;
    textLine_t  t;
    rd = 5'($random(seed));
    $sformat(t, "jal x%0d, %0d", rd, int'($signed(off)));
    sendWord({off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL}, t);
  endtask

  task automatic sendUpper(input string name, input logic [6:0] opc, input logic [19:0] field);
    logic [4:0] rd;
    textLine_t  t;
    rd = 5'($random(seed));
    $sformat(t, "%s x%0d, 0x%0h", name, rd, field);
    sendWord({field, rd, opc}, t);
  endtask

  task automatic sendBare(input string name, input instrWord_t w);
    textLine_t t;
    $sformat(t, "%s", name);
    sendWord(w, t);
  endtask

  task automatic streamWithBackpressure(input int count);
    logic [11:0] field;
    for (int i = 0; i < count; i++) begin
      field = 12'($random(seed));
      if ($random(seed) & 1) sendRType("xor", 7'b0000000, 3'b100);
      else sendImm("addi", 3'b000, field, int'($signed(field)));
    end
  endtask

  initial begin
    logic [11:0] field;
    logic [4:0]  shamt;
    seed = 32'h7ba92bba;
    errors = 0;
    sent = 0;
    received = 0;
    stressReady = 1'b0;
    anyAccepted = 1'b0;
    expReady = 1'b1;
    rst = 1'b1;
    instrValid = 1'b0;
    instr = '0;
    lineReady = 1'b1;
    curExp = '0;
    expLine = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // lineValid has to stay low over these idle cycles
    repeat (4) @(posedge clk);

    for (int i = 0; i < 3; i++) begin
      sendRType("add", 7'b0000000, 3'b000);
      sendRType("sub", 7'b0100000, 3'b000);
      sendRType("sll", 7'b0000000, 3'b001);
      sendRType("xor", 7'b0000000, 3'b100);
      sendRType("sra", 7'b0100000, 3'b101);
      sendRType("mul", `FUNCT7_MULDIV, 3'b000);
      sendRType("mulhu", `FUNCT7_MULDIV, 3'b011);
      sendRType("div", `FUNCT7_MULDIV, 3'b100);
      sendRType("remu", `FUNCT7_MULDIV, 3'b111);
      field = 12'($random(seed));
      sendImm("addi", 3'b000, field, int'($signed(field)));
      field = 12'($random(seed));
      sendImm("sltiu", 3'b011, field, int'($signed(field)));
      field = 12'($random(seed));
      sendImm("andi", 3'b111, field, int'($signed(field)));
    end
    sendImm("addi", 3'b000, 12'h800, -2048);
    sendImm("addi", 3'b000, 12'h7ff, 2047);
    for (int i = 0; i < 2; i++) begin
      shamt = 5'($random(seed));
      sendImm("slli", 3'b001, {7'b0000000, shamt}, int'(shamt));
      shamt = 5'($random(seed));
      sendImm("srli", 3'b101, {7'b0000000, shamt}, int'(shamt));
      shamt = 5'($random(seed));
      sendImm("srai", 3'b101, {7'b0100000, shamt}, int'(shamt));
    end

    sendMem("lb", `OPC_LOAD, 3'b000, 12'($random(seed)));
    sendMem("lh", `OPC_LOAD, 3'b001, 12'($random(seed)));
    sendMem("lw", `OPC_LOAD, 3'b010, 12'h800);
    sendMem("lbu", `OPC_LOAD, 3'b100, 12'($random(seed)));
    sendMem("lhu", `OPC_LOAD, 3'b101, 12'h7ff);
    sendMem("jalr", `OPC_JALR, 3'b000, 12'($random(seed)));
    sendMem("jalr", `OPC_JALR, 3'b000, 12'hffc);
    for (int i = 0; i < 2; i++) begin
      sendMem("sb", `OPC_STORE, 3'b000, 12'($random(seed)));
      sendMem("sh", `OPC_STORE, 3'b001, 12'($random(seed)));
      sendMem("sw", `OPC_STORE, 3'b010, 12'($random(seed)));
      sendBranch("beq", 3'b000, 13'($random(seed) & ~1));
      sendBranch("bne", 3'b001, 13'($random(seed) & ~1));
      sendBranch("blt", 3'b100, 13'($random(seed) & ~1));
      sendBranch("bge", 3'b101, 13'($random(seed) & ~1));
      sendBranch("bltu", 3'b110, 13'($random(seed) & ~1));
      sendBranch("bgeu", 3'b111, 13'($random(seed) & ~1));
      sendJal(21'($random(seed) & ~1));
      sendUpper("lui", `OPC_LUI, 20'($random(seed)));
      sendUpper("auipc", `OPC_AUIPC, 20'($random(seed)));
    end
    // Extreme offsets and a short hex field
    sendBranch("beq", 3'b000, 13'h1000);
    sendBranch("bne", 3'b001, 13'h0ffe);
    sendJal(21'h100000);
    sendJal(21'h0ffffe);
    sendUpper("lui", `OPC_LUI, 20'h00001);

    sendBare("fence", 32'h0ff0000f);
    sendBare("ecall", 32'h00000073);
    sendBare("ebreak", 32'h00100073);
    sendBare("mret", 32'h30200073);
    sendBare("wfi", 32'h10500073);
    sendBare("illegal", 32'h00000000);
    sendBare("illegal", 32'hffffffff);
    sendBare("illegal", {7'b0000010, 5'd3, 5'd4, 3'b000, 5'd5, `OPC_OP});
    sendBare("illegal", {7'b0000000, 5'd1, 5'd2, 3'b010, 5'd8, `OPC_BRANCH});
    sendBare("illegal", {7'b0000000, 5'd6, 5'd7, 3'b011, 5'd8, `OPC_BRANCH});

    stressReady <= 1'b1;
    streamWithBackpressure(40);
    instrValid <= 1'b0;
    stressReady <= 1'b0;
    while (expQ.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);

    assert (sent == received) else begin
      errors++;
      $display("Word and line counts differ: %0d words sent, %0d lines received",
               sent, received);
    end
    $display("Errors: %0d, words sent: %0d, lines received: %0d", errors, sent, received);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- disassembler.sv
`timescale 1ns/1ps
`default_nettype none

module disassembler import disasm_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       instrValid,
  output logic       instrReady,
  input  instrWord_t instr,
  output logic       lineValid,
  input  logic       lineReady,
  output textLine_t  line
);

  decodedInstr_t decNow;
  decodedInstr_t decHeld;
  logic          decValid;
  logic          decReady;
  textLine_t     lineNow;

  instrDecoder u_decoder (
    .instr (instr),
    .dec   (decNow)
  );

  pipeStage #(.T(decodedInstr_t)) u_decStage (
    .clk      (clk),
    .rst      (rst),
    .inValid  (instrValid),
    .inReady  (instrReady),
    .inData   (decNow),
    .outValid (decValid),
    .outReady (decReady),
    .outData  (decHeld)
  );

  operandFormatter u_formatter (
    .dec  (decHeld),
    .line (lineNow)
  );

  // Output register one cycle behind the decode stage
  pipeStage #(.T(textLine_t)) u_lineStage (
    .clk      (clk),
    .rst      (rst),
    .inValid  (decValid),
    .inReady  (decReady),
    .inData   (lineNow),
    .outValid (lineValid),
    .outReady (lineReady),
    .outData  (line)
  );

endmodule

`default_nettype wire

//--- pipeStage.sv
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  output logic inReady,
  input  T     inData,
  output logic outValid,
  input  logic outReady,
  output T     outData
);

  // Room when empty or the held item leaves this cycle
  assign inReady = !outValid || outReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      outData <= inData;
    end
  end

endmodule

`default_nettype wire

//--- operandFormatter.sv
`timescale 1ns/1ps
`default_nettype none

module operandFormatter import disasm_pkg::*; (
  input  decodedInstr_t dec,
  output textLine_t     line
);

  // Indexed by mnemonic_e
  localparam logic [55:0] mnemonicText [51] = '{
    "illegal",
    "lui", "auipc", "jal", "jalr",
    "beq", "bne", "blt", "bge", "bltu", "bgeu",
    "lb", "lh", "lw", "lbu", "lhu",
    "sb", "sh", "sw",
    "addi", "slti", "sltiu", "xori", "ori", "andi",
    "slli", "srli", "srai",
    "add", "sub", "sll", "slt", "sltu", "xor", "srl", "sra", "or", "and",
    "fence", "ecall", "ebreak", "mret", "wfi",
    "mul", "mulh", "mulhsu", "mulhu", "div", "divu", "rem", "remu"
  };

  logic [4:0] memReg;

  // Shift left one byte and drop the new character in at the right
  function automatic textLine_t putChar(textLine_t text, logic [7:0] ch);
    return {text[$bits(textLine_t)-9:0], ch};
  endfunction

  function automatic textLine_t putSep(textLine_t text);
    return putChar(putChar(text, ","), " ");
  endfunction

  // Seven digits cover the largest J offset
  function automatic textLine_t putDec(textLine_t text, logic signed [31:0] value);
    logic [31:0] mag;
    logic [3:0]  digit [7];
    logic        lead;
    textLine_t   res;
    res = text;
    mag = (value < 0) ? -value : value;
    if (value < 0) res = putChar(res, "-");
    for (int i = 0; i < 7; i++) begin
      digit[i] = 4'(mag % 10);
      mag = mag / 10;
    end
    lead = 1'b1;
    for (int i = 6; i >= 0; i--) begin
      if (digit[i] != 4'd0 || !lead || i == 0) begin
        res = putChar(res, {4'h3, digit[i]});
        lead = 1'b0;
      end
    end
    return res;
  endfunction

  function automatic textLine_t putHex(textLine_t text, logic [19:0] value);
    logic [3:0] nib;
    logic       lead;
    textLine_t  res;
    res = putChar(putChar(text, "0"), "x");
    lead = 1'b1;
    for (int i = 4; i >= 0; i--) begin
      nib = value[i*4 +: 4];
      if (nib != 4'd0 || !lead || i == 0) begin
        res = putChar(res, (nib < 4'd10) ? {4'h3, nib} : 8'h57 + 8'(nib));
        lead = 1'b0;
      end
    end
    return res;
  endfunction

  function automatic textLine_t putReg(textLine_t text, logic [4:0] r);
    return putDec(putChar(text, "x"), 32'(r));
  endfunction

  assign memReg = (dec.mnemonic inside {SB, SH, SW}) ? dec.rs2 : dec.rd;

  always_comb begin
    line = textLine_t'(mnemonicText[dec.mnemonic]);
    if (dec.layout != LAY_NONE) line = putChar(line, " ");
    case (dec.layout)
      LAY_RRR: begin
        line = putReg(line, dec.rd);
        line = putReg(putSep(line), dec.rs1);
        line = putReg(putSep(line), dec.rs2);
      end
      LAY_RRI: begin
        line = putReg(line, dec.rd);
        line = putReg(putSep(line), dec.rs1);
        line = putDec(putSep(line), dec.imm);
      end
      LAY_MEM: begin
        line = putReg(line, memReg);
        line = putDec(putSep(line), dec.imm);
        line = putChar(line, "(");
        line = putChar(putReg(line, dec.rs1), ")");
      end
      LAY_BR: begin
        line = putReg(line, dec.rs1);
        line = putReg(putSep(line), dec.rs2);
        line = putDec(putSep(line), dec.imm);
      end
      LAY_RU: begin
        line = putReg(line, dec.rd);
        line = putHex(putSep(line), dec.imm[31:12]);
      end
      LAY_RJ: begin
        line = putReg(line, dec.rd);
        line = putDec(putSep(line), dec.imm);
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "disasm_consts.svh"

module instrDecoder import disasm_pkg::*; (
  input  instrWord_t    instr,
  output decodedInstr_t dec
);

  localparam logic [6:0] funct7Base = 7'b0000000;
  localparam logic [6:0] funct7Alt  = 7'b0100000;

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic signed [31:0] immI;
  logic signed [31:0] immS;
  logic signed [31:0] immB;
  logic signed [31:0] immU;
  logic signed [31:0] immJ;
  logic signed [31:0] shamt;
  logic signed [31:0] imm;
  mnemonic_e          mnem;
  layout_e            lay;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign immI  = {{20{instr[31]}}, instr[31:20]};
  assign immS  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU  = {instr[31:12], 12'b0};
  assign immJ  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign shamt = {27'b0, instr[24:20]};

  always_comb begin
    mnem = ILLEGAL;
    case (opcode)
      `OPC_LUI:     mnem = LUI;
      `OPC_AUIPC:   mnem = AUIPC;
      `OPC_JAL:     mnem = JAL;
      `OPC_JALR:    if (funct3 == 3'b000) mnem = JALR;
      `OPC_MISCMEM: if (funct3 == 3'b000) mnem = FENCE;
      `OPC_BRANCH: begin
        case (funct3)
          3'b000:  mnem = BEQ;
          3'b001:  mnem = BNE;
          3'b100:  mnem = BLT;
          3'b101:  mnem = BGE;
          3'b110:  mnem = BLTU;
          3'b111:  mnem = BGEU;
          default: mnem = ILLEGAL;
        endcase
      end
      `OPC_LOAD: begin
        case (funct3)
          3'b000:  mnem = LB;
          3'b001:  mnem = LH;
          3'b010:  mnem = LW;
          3'b100:  mnem = LBU;
          3'b101:  mnem = LHU;
          default: mnem = ILLEGAL;
        endcase
      end
      `OPC_STORE: begin
        case (funct3)
          3'b000:  mnem = SB;
          3'b001:  mnem = SH;
          3'b010:  mnem = SW;
          default: mnem = ILLEGAL;
        endcase
      end
      `OPC_OPIMM: begin
        case (funct3)
          3'b000: mnem = ADDI;
          3'b010: mnem = SLTI;
          3'b011: mnem = SLTIU;
          3'b100: mnem = XORI;
          3'b110: mnem = ORI;
          3'b111: mnem = ANDI;
          3'b001: if (funct7 == funct7Base) mnem = SLLI;
          default: begin
            if (funct7 == funct7Base) mnem = SRLI;
            else if (funct7 == funct7Alt) mnem = SRAI;
          end
        endcase
      end
      `OPC_OP: begin
        case ({funct7, funct3})
          {funct7Base, 3'b000}:     mnem = ADD;
          {funct7Alt, 3'b000}:      mnem = SUB;
          {funct7Base, 3'b001}:     mnem = SLL;
          {funct7Base, 3'b010}:     mnem = SLT;
          {funct7Base, 3'b011}:     mnem = SLTU;
          {funct7Base, 3'b100}:     mnem = XOR;
          {funct7Base, 3'b101}:     mnem = SRL;
          {funct7Alt, 3'b101}:      mnem = SRA;
          {funct7Base, 3'b110}:     mnem = OR;
          {funct7Base, 3'b111}:     mnem = AND;
          {`FUNCT7_MULDIV, 3'b000}: mnem = MUL;
          {`FUNCT7_MULDIV, 3'b001}: mnem = MULH;
          {`FUNCT7_MULDIV, 3'b010}: mnem = MULHSU;
          {`FUNCT7_MULDIV, 3'b011}: mnem = MULHU;
          {`FUNCT7_MULDIV, 3'b100}: mnem = DIV;
          {`FUNCT7_MULDIV, 3'b101}: mnem = DIVU;
          {`FUNCT7_MULDIV, 3'b110}: mnem = REM;
          {`FUNCT7_MULDIV, 3'b111}: mnem = REMU;
          default:                  mnem = ILLEGAL;
        endcase
      end
      // Whole word fixed apart from the opcode
      `OPC_SYSTEM: begin
        case (instr[31:7])
          25'h0:              mnem = ECALL;
          {12'h001, 13'h0}:   mnem = EBREAK;
          {12'h302, 13'h0}:   mnem = MRET;
          {12'h105, 13'h0}:   mnem = WFI;
          default:            mnem = ILLEGAL;
        endcase
      end
      default: mnem = ILLEGAL;
    endcase
  end

  // Layout and immediate follow the opcode alone
  always_comb begin
    lay = LAY_NONE;
    imm = '0;
    case (opcode)
      `OPC_OP: lay = LAY_RRR;
      `OPC_OPIMM: begin
        lay = LAY_RRI;
        imm = (funct3[1:0] == 2'b01) ? shamt : immI;
      end
      `OPC_LOAD, `OPC_JALR: begin
        lay = LAY_MEM;
        imm = immI;
      end
      `OPC_STORE: begin
        lay = LAY_MEM;
        imm = immS;
      end
      `OPC_BRANCH: begin
        lay = LAY_BR;
        imm = immB;
      end
      `OPC_LUI, `OPC_AUIPC: begin
        lay = LAY_RU;
        imm = immU;
      end
      `OPC_JAL: begin
        lay = LAY_RJ;
        imm = immJ;
      end
      default: lay = LAY_NONE;
    endcase
  end

  assign dec = '{
    mnemonic: mnem,
    layout:   (mnem == ILLEGAL) ? LAY_NONE : lay,
    rd:       instr[11:7],
    rs1:      instr[19:15],
    rs2:      instr[24:20],
    imm:      imm
  };

endmodule

`default_nettype wire

//--- disasm_pkg.sv
`default_nettype none

`include "disasm_consts.svh"

package disasm_pkg;

  typedef logic [`DISASM_INSTR_W-1:0] instrWord_t;

  // The formatter name table follows this order
  typedef enum logic [5:0] {
    ILLEGAL,
    LUI, AUIPC, JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LB, LH, LW, LBU, LHU,
    SB, SH, SW,
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
    SLLI, SRLI, SRAI,
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    FENCE, ECALL, EBREAK, MRET, WFI,
    MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
  } mnemonic_e;

  typedef enum logic [2:0] {
    LAY_RRR,
    LAY_RRI,
    LAY_MEM,
    LAY_BR,
    LAY_RU,
    LAY_RJ,
    LAY_NONE
  } layout_e;

  // Stores print rs2 as their first register
  typedef struct packed {
    mnemonic_e          mnemonic;
    layout_e            layout;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic signed [31:0] imm;
  } decodedInstr_t;

  // Right-aligned ASCII with NUL bytes on the left
  typedef logic [`DISASM_TEXT_CHARS*8-1:0] textLine_t;

endpackage

`default_nettype wire

//--- disasm_consts.svh
`ifndef DISASM_CONSTS_SVH
`define DISASM_CONSTS_SVH

// Word and text sizes
`define DISASM_INSTR_W    32
`define DISASM_TEXT_CHARS 32

// Major opcodes in bits 6:0 of the word
`define OPC_OP      7'b0110011
`define OPC_OPIMM   7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_MISCMEM 7'b0001111
`define OPC_SYSTEM  7'b1110011

// M extension inside OP
`define FUNCT7_MULDIV 7'b0000001

`endif
